/* include/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// cycles from bank start to its done pulse
`define MEM_LATENCY 3

// word-interleaved banks, low address bits pick the bank
`define NUM_BANKS 4
`define BANK_AW 6

// on-chip memories
`define CHAR_AW 6
`define LOADER_AW 4

`endif

/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // data and instruction words
    typedef logic [31:0] word_t;

    // word address, byte offset already dropped by the CPU
    typedef logic [29:0] addr_t;

    // targets of a data access, from the top four address bits
    typedef enum logic [2:0] {
        REG_MAIN,
        REG_VMEM,
        REG_TIMER,
        REG_KBD,
        REG_LOADER
    } region_t;

    // per-bank access state
    typedef enum logic {
        BANK_IDLE,
        BANK_BUSY
    } bank_state_t;

endpackage

`default_nettype wire

/* verilog/addr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module addr_decoder (
    input  logic           ui_clk,
    input  logic           rst,
    input  logic           dmem_read,
    input  logic           dmem_write,
    input  mem_pkg::addr_t dmem_addr,
    input  logic [3:0]     dmem_byte_w_en,
    input  mem_pkg::word_t data_from_reg,
    input  mem_pkg::addr_t instr_addr,
    input  mem_pkg::word_t loader_data,
    input  mem_pkg::word_t main_rdata,
    input  logic           dispatch_stall,
    output logic           main_read,
    output logic           main_write,
    output logic           vmem_wen,
    output logic [`CHAR_AW-1:0] char_addr,
    output logic [7:0]     char_data,
    output logic           mem_stall,
    output mem_pkg::word_t dmem_data_out,
    output mem_pkg::word_t instr_data_out
);
    import mem_pkg::*;

    localparam int CAW = `CHAR_AW;

    region_t    region;
    logic       vmem_req;
    logic       vmem_toggle;
    logic       vmem_stall;
    logic [1:0] lane;

    ////////////////////////////////////////////////////////////////////////////
    // region decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (dmem_addr[29:26])
            4'hc:    region = REG_VMEM;
            4'hd:    region = REG_TIMER;
            4'he:    region = REG_KBD;
            4'hf:    region = REG_LOADER;
            default: region = REG_MAIN;
        endcase
    end

    // only main memory reaches the banks
    assign main_read  = dmem_read  & (region == REG_MAIN);
    assign main_write = dmem_write & (region == REG_MAIN);

    ////////////////////////////////////////////////////////////////////////////
    // video memory, one wait cycle then the write
    ////////////////////////////////////////////////////////////////////////////
    assign vmem_req = (dmem_read | dmem_write) & (region == REG_VMEM);

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            vmem_toggle <= 1'b0;
        end else if (vmem_req) begin
            vmem_toggle <= ~vmem_toggle;
        end else begin
            vmem_toggle <= 1'b0;
        end
    end

    assign vmem_stall = vmem_req & ~vmem_toggle;
    assign vmem_wen   = dmem_write & (region == REG_VMEM) & vmem_toggle;

    // enable bit 3 is lane 0, the low byte of the word
    always_comb begin
        case (dmem_byte_w_en)
            4'b1000: begin
                lane      = 2'd0;
                char_data = data_from_reg[7:0];
            end
            4'b0100: begin
                lane      = 2'd1;
                char_data = data_from_reg[15:8];
            end
            4'b0010: begin
                lane      = 2'd2;
                char_data = data_from_reg[23:16];
            end
            default: begin
                lane      = 2'd3;
                char_data = data_from_reg[31:24];
            end
        endcase
    end

    assign char_addr = CAW'({dmem_addr, lane});

    assign mem_stall = dispatch_stall | vmem_stall;

    // timer, keyboard and vmem reads give zero
    assign dmem_data_out  = (region == REG_MAIN) ? main_rdata : '0;
    assign instr_data_out = (instr_addr[29:26] == 4'hf) ? loader_data : '0;

endmodule

`default_nettype wire

/* verilog/bank_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module bank_dispatch (
    input  logic                         ui_clk,
    input  logic                         rst,
    input  logic                         main_read,
    input  logic                         main_write,
    input  logic [$clog2(`NUM_BANKS)-1:0] bank_sel,
    input  logic [`NUM_BANKS-1:0]        bank_done,
    output logic [`NUM_BANKS-1:0]        bank_start,
    output logic                         dispatch_stall
);

    logic req;
    logic busy;
    logic launch;
    logic any_done;

    assign req      = main_read | main_write;
    assign any_done = |bank_done;

    // one access in flight, the CPU waits for it
    assign launch = req & ~busy;

    always_comb begin
        bank_start = '0;
        if (launch) begin
            bank_start[bank_sel] = 1'b1;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            busy <= 1'b0;
        end else if (any_done) begin
            busy <= 1'b0;
        end else if (launch) begin
            busy <= 1'b1;
        end
    end

    // released in the done cycle, so the next access can start right after
    assign dispatch_stall = req & ~any_done;

endmodule

`default_nettype wire

/* verilog/ram_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module ram_bank (
    input  logic                ui_clk,
    input  logic                rst,
    input  logic                start,
    input  logic                write,
    input  logic [`BANK_AW-1:0] word_addr,
    input  logic [3:0]          byte_w_en,
    input  mem_pkg::word_t      wdata,
    output logic                done,
    output mem_pkg::word_t      rdata
);
    import mem_pkg::*;

    localparam int DEPTH = 2 ** `BANK_AW;
    localparam int CNT_W = $clog2(`MEM_LATENCY);

    bank_state_t         state;
    logic [CNT_W-1:0]    cnt;
    logic                op_write;
    logic [`BANK_AW-1:0] op_addr;
    logic [3:0]          op_be;
    word_t               op_wdata;
    word_t               mem [DEPTH];

    // operands captured when the access starts
    always_ff @(posedge ui_clk) begin
        if (start && state == BANK_IDLE) begin
            op_addr  <= word_addr;
            op_be    <= byte_w_en;
            op_wdata <= wdata;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state    <= BANK_IDLE;
            cnt      <= '0;
            op_write <= 1'b0;
            done     <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            done <= 1'b0;
            case (state)
                BANK_IDLE: begin
                    if (start) begin
                        state    <= BANK_BUSY;
                        cnt      <= CNT_W'(`MEM_LATENCY - 1);
                        op_write <= write;
                    end
                end
                BANK_BUSY: begin
                    if (cnt == CNT_W'(1)) begin
                        state <= BANK_IDLE;
                        done  <= 1'b1;
                        // enable bit 3 writes the low byte
                        if (op_write) begin
                            for (int b = 0; b < 4; b++) begin
                                if (op_be[3-b]) begin
                                    mem[op_addr][8*b +: 8] <= op_wdata[8*b +: 8];
                                end
                            end
                        end else begin
                            rdata <= mem[op_addr];
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= BANK_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/bank_collect.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module bank_collect (
    input  logic [`NUM_BANKS-1:0] bank_done,
    input  mem_pkg::word_t        bank_rdata [`NUM_BANKS],
    output mem_pkg::word_t        main_rdata
);

    // at most one done bit is set at a time
    always_comb begin
        main_rdata = '0;
        for (int i = 0; i < `NUM_BANKS; i++) begin
            if (bank_done[i]) begin
                main_rdata = bank_rdata[i];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/onchip_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module onchip_mem (
    input  logic                ui_clk,
    input  logic                rst,
    input  mem_pkg::addr_t      instr_addr,
    input  logic                vmem_wen,
    input  logic [`CHAR_AW-1:0] char_addr,
    input  logic [7:0]          char_data,
    input  logic [`CHAR_AW-1:0] disp_addr,
    output mem_pkg::word_t      loader_data,
    output logic [7:0]          disp_char
);
    import mem_pkg::*;

    localparam int ROM_DEPTH  = 2 ** `LOADER_AW;
    localparam int CHAR_DEPTH = 2 ** `CHAR_AW;

    word_t      rom [ROM_DEPTH];
    logic [7:0] char_mem [CHAR_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // loader ROM
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        $readmemh("loader_image.hex", rom);
    end

    // region bits are ignored, the decoder picks region 0xf
    assign loader_data = rom[instr_addr[`LOADER_AW-1:0]];

    ////////////////////////////////////////////////////////////////////////////
    // character RAM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            for (int i = 0; i < CHAR_DEPTH; i++) begin
                char_mem[i] <= 8'h00;
            end
        end else if (vmem_wen) begin
            char_mem[char_addr] <= char_data;
        end
    end

    // display side
    assign disp_char = char_mem[disp_addr];

endmodule

`default_nettype wire

/* verilog/cpu_interface.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module cpu_interface (
    input  logic                ui_clk,
    input  logic                rst,
    input  logic                dmem_read,
    input  logic                dmem_write,
    input  mem_pkg::addr_t      dmem_addr,
    input  logic [3:0]          dmem_byte_w_en,
    input  mem_pkg::word_t      data_from_reg,
    input  mem_pkg::addr_t      instr_addr,
    input  logic [`CHAR_AW-1:0] disp_addr,
    output mem_pkg::word_t      dmem_data_out,
    output mem_pkg::word_t      instr_data_out,
    output logic [7:0]          disp_char,
    output logic                mem_stall
);
    import mem_pkg::*;

    localparam int SEL_W = $clog2(`NUM_BANKS);

    logic                main_read;
    logic                main_write;
    logic                dispatch_stall;
    logic                vmem_wen;
    logic [`CHAR_AW-1:0] char_addr;
    logic [7:0]          char_data;
    word_t               loader_data;
    word_t               main_rdata;
    logic [`NUM_BANKS-1:0] bank_start;
    logic [`NUM_BANKS-1:0] bank_done;
    word_t               bank_rdata [`NUM_BANKS];

    addr_decoder addr_decoder_inst (
        .ui_clk         (ui_clk),
        .rst            (rst),
        .dmem_read      (dmem_read),
        .dmem_write     (dmem_write),
        .dmem_addr      (dmem_addr),
        .dmem_byte_w_en (dmem_byte_w_en),
        .data_from_reg  (data_from_reg),
        .instr_addr     (instr_addr),
        .loader_data    (loader_data),
        .main_rdata     (main_rdata),
        .dispatch_stall (dispatch_stall),
        .main_read      (main_read),
        .main_write     (main_write),
        .vmem_wen       (vmem_wen),
        .char_addr      (char_addr),
        .char_data      (char_data),
        .mem_stall      (mem_stall),
        .dmem_data_out  (dmem_data_out),
        .instr_data_out (instr_data_out)
    );

    // low address bits choose the bank
    bank_dispatch bank_dispatch_inst (
        .ui_clk         (ui_clk),
        .rst            (rst),
        .main_read      (main_read),
        .main_write     (main_write),
        .bank_sel       (dmem_addr[SEL_W-1:0]),
        .bank_done      (bank_done),
        .bank_start     (bank_start),
        .dispatch_stall (dispatch_stall)
    );

    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
        ram_bank ram_bank_inst (
            .ui_clk    (ui_clk),
            .rst       (rst),
            .start     (bank_start[g]),
            .write     (main_write),
            .word_addr (dmem_addr[`BANK_AW+SEL_W-1:SEL_W]),
            .byte_w_en (dmem_byte_w_en),
            .wdata     (data_from_reg),
            .done      (bank_done[g]),
            .rdata     (bank_rdata[g])
        );
    end

    bank_collect bank_collect_inst (
        .bank_done  (bank_done),
        .bank_rdata (bank_rdata),
        .main_rdata (main_rdata)
    );

    onchip_mem onchip_mem_inst (
        .ui_clk      (ui_clk),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .vmem_wen    (vmem_wen),
        .char_addr   (char_addr),
        .char_data   (char_data),
        .disp_addr   (disp_addr),
        .loader_data (loader_data),
        .disp_char   (disp_char)
    );

endmodule

`default_nettype wire

/* tests/cpu_interface_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module cpu_interface_asserts (
    input  logic                  ui_clk,
    input  logic                  rst,
    input  logic                  mem_stall,
    input  logic                  vmem_stall,
    input  mem_pkg::bank_state_t  bank0_state,
    input  mem_pkg::bank_state_t  bank1_state,
    input  mem_pkg::bank_state_t  bank2_state,
    input  mem_pkg::bank_state_t  bank3_state
);
    import mem_pkg::*;

    int         stall_run;
    logic [3:0] busy;

    // stall cycles seen before the current one
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            stall_run <= 0;
        end else if (mem_stall) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    assign busy = {bank3_state == BANK_BUSY, bank2_state == BANK_BUSY,
                   bank1_state == BANK_BUSY, bank0_state == BANK_BUSY};

    stall_length_a: assert property (
        @(posedge ui_clk) disable iff (!rst)
        mem_stall |-> (stall_run < `MEM_LATENCY)
    ) else $error("mem_stall held longer than the memory latency");

    single_bank_a: assert property (
        @(posedge ui_clk) disable iff (!rst)
        $onehot0(busy)
    ) else $error("more than one bank busy at once");

    // vmem wait is a single cycle at the CPU side
    vmem_stall_a: assert property (
        @(posedge ui_clk) disable iff (!rst)
        vmem_stall |=> !mem_stall
    ) else $error("vmem stall lasted more than one cycle");

endmodule

bind cpu_interface cpu_interface_asserts cpu_interface_asserts_inst (
    .ui_clk      (ui_clk),
    .rst         (rst),
    .mem_stall   (mem_stall),
    .vmem_stall  (addr_decoder_inst.vmem_stall),
    .bank0_state (g_bank[0].ram_bank_inst.state),
    .bank1_state (g_bank[1].ram_bank_inst.state),
    .bank2_state (g_bank[2].ram_bank_inst.state),
    .bank3_state (g_bank[3].ram_bank_inst.state)
);

`default_nettype wire

/* tests/cpu_interface_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module cpu_interface_tb;
    import mem_pkg::*;

    localparam int CLK_HALF = 50;

    logic                ui_clk;
    logic                rst;
    logic                dmem_read;
    logic                dmem_write;
    addr_t               dmem_addr;
    logic [3:0]          dmem_byte_w_en;
    word_t               data_from_reg;
    addr_t               instr_addr;
    logic [`CHAR_AW-1:0] disp_addr;
    word_t               dmem_data_out;
    word_t               instr_data_out;
    logic [7:0]          disp_char;
    logic                mem_stall;

    // vectors as read from the data file
    byte         op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] be_q[$];
    logic [31:0] wdata_q[$];
    logic [31:0] exp_q[$];

    int cycle_count = 0;
    int cycle_limit = 0;

    cpu_interface cpu_interface_inst (
        .ui_clk         (ui_clk),
        .rst            (rst),
        .dmem_read      (dmem_read),
        .dmem_write     (dmem_write),
        .dmem_addr      (dmem_addr),
        .dmem_byte_w_en (dmem_byte_w_en),
        .data_from_reg  (data_from_reg),
        .instr_addr     (instr_addr),
        .disp_addr      (disp_addr),
        .dmem_data_out  (dmem_data_out),
        .instr_data_out (instr_data_out),
        .disp_char      (disp_char),
        .mem_stall      (mem_stall)
    );

    initial begin
        ui_clk = 1'b0;
        forever begin
            #CLK_HALF ui_clk = ~ui_clk;
        end
    end

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // watchdog
    always @(posedge ui_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("DUT stalled past the limit of %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////////////////////
    function automatic region_t region_of(input addr_t addr);
        case (addr[29:26])
            4'hc:    return REG_VMEM;
            4'hd:    return REG_TIMER;
            4'he:    return REG_KBD;
            4'hf:    return REG_LOADER;
            default: return REG_MAIN;
        endcase
    endfunction

    function automatic int expected_stalls(input region_t target);
        if (target == REG_MAIN) begin
            return `MEM_LATENCY;
        end else if (target == REG_VMEM) begin
            return 1;
        end
        return 0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_char(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_stalls(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error: %s stall cycles expected %0d actual %0d", name, expected, actual);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // vector file and access tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        byte         op;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] wdata;
        logic [31:0] expected;
        fd = $fopen("tests/mem_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/mem_vectors.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and blank lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %h %h", op, addr, be, wdata, expected);
            if (fields == 5) begin
                op_q.push_back(op);
                addr_q.push_back(addr);
                be_q.push_back(be);
                wdata_q.push_back(wdata);
                exp_q.push_back(expected);
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            $display("no vectors found in tests/mem_vectors.txt");
            stop_with_failure();
        end
    endtask

    // holds the request until mem_stall is low at a rising edge
    task automatic do_data_access(input string name, input logic is_write, input addr_t addr,
                                  input logic [3:0] be, input word_t wdata,
                                  input word_t expected);
        int    stalls;
        word_t rdata;
        stalls = 0;
        @(negedge ui_clk);
        dmem_read      = ~is_write;
        dmem_write     = is_write;
        dmem_addr      = addr;
        dmem_byte_w_en = be;
        data_from_reg  = wdata;
        @(posedge ui_clk);
        while (mem_stall) begin
            stalls++;
            @(posedge ui_clk);
        end
        rdata = dmem_data_out;
        check_stalls(name, expected_stalls(region_of(addr)), stalls);
        if (!is_write) begin
            check_word(name, expected, rdata);
        end
    endtask

    task automatic do_fetch(input string name, input addr_t addr, input word_t expected);
        @(negedge ui_clk);
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        instr_addr = addr;
        @(posedge ui_clk);
        check_word(name, expected, instr_data_out);
    endtask

    task automatic do_display_read(input string name, input logic [`CHAR_AW-1:0] addr,
                                   input logic [7:0] expected);
        @(negedge ui_clk);
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        disp_addr  = addr;
        @(posedge ui_clk);
        check_char(name, expected, disp_char);
    endtask

    task automatic run_vector(input int idx);
        byte         op;
        logic [31:0] addr;
        region_t     target;
        string       label;
        string       name;
        op     = op_q[idx];
        addr   = addr_q[idx];
        target = region_of(addr[29:0]);
        if (op == "D") begin
            label = "DISPLAY";
        end else begin
            label = target.name();
        end
        name = $sformatf("vector %0d %c %s", idx, op, label);
        case (op)
            "R": do_data_access(name, 1'b0, addr[29:0], be_q[idx][3:0], wdata_q[idx],
                                exp_q[idx]);
            "W": do_data_access(name, 1'b1, addr[29:0], be_q[idx][3:0], wdata_q[idx],
                                exp_q[idx]);
            "I": do_fetch(name, addr[29:0], exp_q[idx]);
            "D": do_display_read(name, addr[`CHAR_AW-1:0], exp_q[idx][7:0]);
            default: begin
                $display("unknown op letter %c in vector %0d", op, idx);
                stop_with_failure();
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst            = 1'b0;
        dmem_read      = 1'b0;
        dmem_write     = 1'b0;
        dmem_addr      = '0;
        dmem_byte_w_en = 4'h0;
        data_from_reg  = '0;
        instr_addr     = '0;
        disp_addr      = '0;

        load_vectors();
        // worst case per vector plus reset and a margin
        cycle_limit = op_q.size() * (`MEM_LATENCY + 2) + 8 + 50;

        repeat (8) @(negedge ui_clk);
        rst = 1'b1;

        for (int i = 0; i < op_q.size(); i++) begin
            run_vector(i);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* loader_image.hex */
// loader ROM, sixteen 32-bit words, two per line from address 0
3c1d0040 27bd0100
3c08c000 24090041
a1090000 0c000010
00000000 1000ffff
8fa40000 8fa50004
00852021 afa40008
03e00008 00000000
deadbeef 0badf00d

/* tests/mem_vectors.txt */
# columns: op addr byte_en wdata expected, all fields in hex
# op is R data read, W data write, I fetch at addr, D display read at addr
W 00000000 f 11223344 00000000
W 00000001 f 55667788 00000000
W 00000002 f 99aabbcc 00000000
W 00000003 f ddeeff00 00000000
R 00000000 0 00000000 11223344
R 00000001 0 00000000 55667788
R 00000002 0 00000000 99aabbcc
R 00000003 0 00000000 ddeeff00
W 00000004 f a5a5a5a5 00000000
W 00000004 8 000000ee 00000000
W 00000004 1 77000000 00000000
W 00000005 6 00abcd00 00000000
W 00000006 c 12345678 00000000
W 00000007 3 12345678 00000000
R 00000004 0 00000000 77a5a5ee
R 00000005 0 00000000 00abcd00
R 00000006 0 00000000 00005678
R 00000007 0 00000000 12340000
R 00000008 0 00000000 00000000
R 000000ff 0 00000000 00000000
W 30000005 8 000000aa 00000000
W 30000005 4 0000bb00 00000000
W 30000005 2 00cc0000 00000000
W 30000005 1 dd000000 00000000
D 00000014 0 00000000 000000aa
D 00000015 0 00000000 000000bb
D 00000016 0 00000000 000000cc
D 00000017 0 00000000 000000dd
D 00000018 0 00000000 00000000
R 00000005 0 00000000 00abcd00
R 30000005 0 00000000 00000000
R 34000001 0 00000000 00000000
W 34000001 f ffffffff 00000000
R 00000001 0 00000000 55667788
R 38000002 0 00000000 00000000
W 38000002 f ffffffff 00000000
R 00000002 0 00000000 99aabbcc
R 3c000001 0 00000000 00000000
I 3c000003 0 00000000 24090041
I 3c00000f 0 00000000 0badf00d
I 3c000010 0 00000000 3c1d0040
I 00000003 0 00000000 00000000
I 34000005 0 00000000 00000000

/* sim.f */
+incdir+include
verilog/mem_pkg.sv
verilog/addr_decoder.sv
verilog/bank_dispatch.sv
verilog/ram_bank.sv
verilog/bank_collect.sv
verilog/onchip_mem.sv
verilog/cpu_interface.sv
tests/cpu_interface_asserts.sv
tests/cpu_interface_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the cpu_interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module cpu_interface_tb -o cpu_interface_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/cpu_interface_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
